//--- files.f
hdl/radio_ctrl_pkg.sv
hdl/setting_ctrl.sv
hdl/fe_atr_ctrl.sv
hdl/radio_misc_regs.sv
hdl/pps_timekeeper.sv
hdl/radio_ctrl_top.sv
bench/radio_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then decide pass or fail from the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module radio_ctrl_tb \
  -f files.f -o radio_ctrl_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/radio_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
  exit 0
fi
exit 1

//--- bench/radio_ctrl_tb.sv
// Self-checking testbench for radio_ctrl_top. A cycle model is checked at every rising edge.
// time_pps is only checked by interval and by staying put, not by absolute value.

`timescale 1ns/1ns

module radio_ctrl_tb;

  import radio_ctrl_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 3;
  localparam int RB_TIMEOUT   = 4;
  localparam int PPS_HIGH     = 3;
  localparam int LATCH_WAIT   = 6;

  // Run length from the test sequence plus slack
  localparam int NUM_WRITES      = 48;
  localparam int NUM_READS       = 20;
  localparam int SWEEP_CYCLES    = 40;
  localparam int PPS_CYCLES      = 120;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_WRITES * 2 +
                                   NUM_READS * (2 + RB_TIMEOUT) + SWEEP_CYCLES +
                                   PPS_CYCLES + 100;

  logic          bus_clk = 1'b0;
  logic          rst;
  set_bus_t      set_bus;
  rb_req_t       rb_req;
  logic [1:0]    tx_active;
  logic [1:0]    rx_active;
  logic          pps_gps;
  logic          pps_ext;
  logic [1:0]    lock_signals;
  logic [31:0]   rb_data;
  logic          rb_valid;
  fe_ctrl_t      fe_ctrl0;
  fe_ctrl_t      fe_ctrl1;
  band_sel_t     band_sel;
  codec_ctrl_t   codec_ctrl;

  // Reference model state
  logic [8:0]    atr0_words [4];
  logic [8:0]    atr1_words [4];
  logic [8:0]    exp_fe0;
  logic [8:0]    exp_fe1;
  logic [16:0]   exp_band;
  logic [1:0]    exp_codec;
  logic [1:0]    exp_pps_sel;
  logic [31:0]   exp_time;
  logic          exp_rb_valid;
  logic          exp_rb_check;
  logic [31:0]   exp_rb_data;
  logic          model_ready = 1'b0;

  int            check_count = 0;
  int            error_count = 0;
  int            cycle_cnt = 0;
  int            rise_cycle;
  int            pps_gap;
  logic [31:0]   lcg_state = 32'h2ffc_4c1e;
  logic [31:0]   rnd;
  logic [31:0]   rd_data;
  logic [31:0]   pps_t1;
  logic [31:0]   pps_t2;
  logic [31:0]   pps_t3;
  logic [7:0]    burst_addr [5] = '{8'h03, 8'h02, 8'h00, 8'h7e, 8'h02};

  radio_ctrl_top u_radio_ctrl_top (
    .bus_clk      (bus_clk),
    .rst          (rst),
    .set_bus      (set_bus),
    .rb_req       (rb_req),
    .rb_data      (rb_data),
    .rb_valid     (rb_valid),
    .tx_active    (tx_active),
    .rx_active    (rx_active),
    .pps_gps      (pps_gps),
    .pps_ext      (pps_ext),
    .lock_signals (lock_signals),
    .fe_ctrl0     (fe_ctrl0),
    .fe_ctrl1     (fe_ctrl1),
    .band_sel     (band_sel),
    .codec_ctrl   (codec_ctrl)
  );

  always #(CLK_PERIOD / 2) bus_clk = ~bus_clk;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED at %0t ns: %s expected 0x%08h, actual 0x%08h",
             $time, name, exp, act);
    error_count++;
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic check_word(input string name, input logic [31:0] exp,
                            input logic [31:0] act);
    check_count++;
    assert (act === exp) else report_mismatch(name, exp, act);
  endtask

  // All bus tasks start and end on a falling edge
  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    @(negedge bus_clk);
    set_bus.stb  = 1'b1;
    set_bus.addr = addr;
    set_bus.data = data;
    @(negedge bus_clk);
    set_bus.stb  = 1'b0;
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    int wait_cycles;
    @(negedge bus_clk);
    rb_req.stb  = 1'b1;
    rb_req.addr = addr;
    @(negedge bus_clk);
    rb_req.stb  = 1'b0;
    wait_cycles = 0;
    while (!rb_valid && wait_cycles < RB_TIMEOUT) begin
      @(negedge bus_clk);
      wait_cycles++;
    end
    assert (rb_valid)
      else report_failure($sformatf("no readback response for address 0x%02h", addr));
    data = rb_data;
  endtask

  // Raise now, hold, drop, then leave time for the latch
  task automatic pulse_pps(input logic gps, input logic ext);
    pps_gps = gps;
    pps_ext = ext;
    repeat (PPS_HIGH) @(negedge bus_clk);
    pps_gps = 1'b0;
    pps_ext = 1'b0;
    repeat (LATCH_WAIT) @(negedge bus_clk);
  endtask

  // --------------------------------------------------------------------------
  // Checker and cycle model
  // --------------------------------------------------------------------------

  always @(posedge bus_clk) begin
    cycle_cnt++;
    if (model_ready) begin
      check_word("fe_ctrl0", 32'(exp_fe0), 32'(fe_ctrl0));
      check_word("fe_ctrl1", 32'(exp_fe1), 32'(fe_ctrl1));
      check_word("band_sel", 32'(exp_band), 32'(band_sel));
      check_word("codec_ctrl", 32'(exp_codec), 32'(codec_ctrl));
      check_word("rb_valid", 32'(exp_rb_valid), 32'(rb_valid));
      if (exp_rb_valid && exp_rb_check) begin
        check_word("rb_data", exp_rb_data, rb_data);
      end
    end
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        atr0_words[i] = '0;
        atr1_words[i] = '0;
      end
      exp_fe0      = '0;
      exp_fe1      = '0;
      exp_band     = '0;
      exp_codec    = '0;
      exp_pps_sel  = '0;
      exp_time     = '0;
      exp_rb_valid = 1'b0;
      exp_rb_check = 1'b0;
      model_ready  = 1'b1;
    end else begin
      // Outputs register the words as they stood before this edge
      exp_fe0      = atr0_words[{tx_active[0], rx_active[0]}];
      exp_fe1      = atr1_words[{tx_active[1], rx_active[1]}];
      exp_rb_valid = rb_req.stb;
      if (rb_req.stb) begin
        exp_rb_check = 1'b1;
        case (rb_req.addr)
          RB_TIME_NOW: exp_rb_data = exp_time;
          RB_TIME_PPS: exp_rb_check = 1'b0;
          RB_STATUS:   exp_rb_data = {26'd0, exp_pps_sel, 2'b00, lock_signals};
          RB_BANDSEL:  exp_rb_data = {15'd0, exp_band};
          default:     exp_rb_data = 32'hdead_beef;
        endcase
      end
      exp_time = exp_time + 32'd1;
      if (set_bus.stb) begin
        case (set_bus.addr)
          ADDR_ATR0_IDLE, ADDR_ATR0_RX, ADDR_ATR0_TX, ADDR_ATR0_FDX:
            atr0_words[set_bus.addr[1:0]] = set_bus.data[8:0];
          ADDR_ATR1_IDLE, ADDR_ATR1_RX, ADDR_ATR1_TX, ADDR_ATR1_FDX:
            atr1_words[set_bus.addr[1:0]] = set_bus.data[8:0];
          ADDR_BANDSEL:    exp_band = set_bus.data[16:0];
          ADDR_CODEC_CTRL: exp_codec = set_bus.data[1:0];
          ADDR_PPS_SEL:    exp_pps_sel = set_bus.data[1:0];
          ADDR_TIME_LOAD:  exp_time = set_bus.data;
          default: ;
        endcase
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  initial begin
    rst          = 1'b1;
    set_bus      = '0;
    rb_req       = '0;
    tx_active    = '0;
    rx_active    = '0;
    pps_gps      = 1'b0;
    pps_ext      = 1'b0;
    lock_signals = '0;
    repeat (RESET_CYCLES) @(negedge bus_clk);
    rst = 1'b0;

    // ATR words, then every state on each channel
    for (int a = 0; a < 8; a++) begin
      write_reg(8'(a), next_rand());
    end
    for (int ch = 0; ch < 2; ch++) begin
      for (int st = 0; st < 4; st++) begin
        @(negedge bus_clk);
        tx_active[ch] = st[1];
        rx_active[ch] = st[0];
        @(negedge bus_clk);
      end
    end
    repeat (16) begin
      rnd = next_rand();
      @(negedge bus_clk);
      tx_active = rnd[1:0];
      rx_active = rnd[3:2];
      write_reg({5'd0, rnd[6:4]}, next_rand());
    end

    // Band select, codec and unmapped writes
    repeat (6) begin
      write_reg(ADDR_BANDSEL, next_rand());
      write_reg(ADDR_CODEC_CTRL, next_rand());
    end
    write_reg(8'h0c, next_rand());
    write_reg(8'h5a, next_rand());
    write_reg(8'hff, next_rand());

    // Every ATR word, PPS source and time must have survived
    for (int st = 0; st < 4; st++) begin
      @(negedge bus_clk);
      tx_active = {2{st[1]}};
      rx_active = {2{st[0]}};
    end
    read_reg(RB_STATUS, rd_data);
    read_reg(RB_TIME_NOW, rd_data);

    // Readback map
    repeat (4) begin
      rnd = next_rand();
      lock_signals = rnd[1:0];
      write_reg(ADDR_PPS_SEL, rnd >> 4);
      read_reg(RB_STATUS, rd_data);
      read_reg(RB_BANDSEL, rd_data);
    end
    read_reg(8'h04, rd_data);
    read_reg(8'ha5, rd_data);
    foreach (burst_addr[i]) begin
      @(negedge bus_clk);
      rb_req.stb   = 1'b1;
      rb_req.addr  = burst_addr[i];
      lock_signals = lock_signals + 2'd1;
    end
    @(negedge bus_clk);
    rb_req.stb = 1'b0;

    // Time load and PPS latch
    write_reg(ADDR_PPS_SEL, 32'(PPS_GPS));
    write_reg(ADDR_TIME_LOAD, next_rand());
    read_reg(RB_TIME_NOW, rd_data);
    repeat (5) @(negedge bus_clk);
    read_reg(RB_TIME_NOW, rd_data);

    pps_gap    = 24 + int'(next_rand() % 32'd16);
    rise_cycle = cycle_cnt;
    pulse_pps(1'b1, 1'b0);
    read_reg(RB_TIME_PPS, pps_t1);
    while (cycle_cnt < rise_cycle + pps_gap) begin
      @(negedge bus_clk);
    end
    pulse_pps(1'b1, 1'b0);
    read_reg(RB_TIME_PPS, pps_t2);
    check_word("time_pps interval", 32'(pps_gap), pps_t2 - pps_t1);

    pulse_pps(1'b0, 1'b1);
    read_reg(RB_TIME_PPS, pps_t3);
    check_word("time_pps after ext pulse", pps_t2, pps_t3);
    write_reg(ADDR_PPS_SEL, 32'(PPS_NONE));
    pulse_pps(1'b1, 1'b1);
    read_reg(RB_TIME_PPS, pps_t3);
    check_word("time_pps with no source", pps_t2, pps_t3);
    write_reg(ADDR_PPS_SEL, 32'd3);
    pulse_pps(1'b1, 1'b1);
    read_reg(RB_TIME_PPS, pps_t3);
    check_word("time_pps with source code 3", pps_t2, pps_t3);

    repeat (4) @(negedge bus_clk);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the test sequence did not finish",
             WATCHDOG_CYCLES);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- hdl/radio_ctrl_top.sv
// Host-controlled part of the two-channel transceiver top level.
// rst must already be synchronous to bus_clk. PPS inputs may be asynchronous.

`timescale 1ns/1ns

module radio_ctrl_top (
  input  logic                                  bus_clk,
  input  logic                                  rst,

  // Host settings and readback
  input  radio_ctrl_pkg::set_bus_t              set_bus,
  input  radio_ctrl_pkg::rb_req_t               rb_req,
  output logic [radio_ctrl_pkg::DATA_W-1:0]     rb_data,
  output logic                                  rb_valid,

  // One bit per channel
  input  logic [1:0]                            tx_active,
  input  logic [1:0]                            rx_active,

  input  logic                                  pps_gps,
  input  logic                                  pps_ext,
  input  logic [1:0]                            lock_signals,

  output radio_ctrl_pkg::fe_ctrl_t              fe_ctrl0,
  output radio_ctrl_pkg::fe_ctrl_t              fe_ctrl1,
  output radio_ctrl_pkg::band_sel_t             band_sel,
  output radio_ctrl_pkg::codec_ctrl_t           codec_ctrl
);

  import radio_ctrl_pkg::*;

  reg_wr_t           reg_wr;
  logic [DATA_W-1:0] set_data;
  logic [DATA_W-1:0] time_now;
  logic [DATA_W-1:0] time_pps;
  pps_src_e          pps_sel;

  // --------------------------------------------------------------------------
  // Settings decode and readback
  // --------------------------------------------------------------------------

  setting_ctrl u_setting_ctrl (
    .bus_clk      (bus_clk),
    .rst          (rst),
    .set_bus      (set_bus),
    .rb_req       (rb_req),
    .time_now     (time_now),
    .time_pps     (time_pps),
    .band_sel     (band_sel),
    .pps_sel      (pps_sel),
    .lock_signals (lock_signals),
    .reg_wr       (reg_wr),
    .set_data     (set_data),
    .rb_data      (rb_data),
    .rb_valid     (rb_valid)
  );

  // --------------------------------------------------------------------------
  // Front-end control, one instance per channel
  // --------------------------------------------------------------------------

  fe_atr_ctrl u_fe0 (
    .bus_clk   (bus_clk),
    .rst       (rst),
    .atr_wr    (reg_wr.atr0),
    .set_data  (set_data),
    .tx_active (tx_active[0]),
    .rx_active (rx_active[0]),
    .fe_ctrl   (fe_ctrl0)
  );

  fe_atr_ctrl u_fe1 (
    .bus_clk   (bus_clk),
    .rst       (rst),
    .atr_wr    (reg_wr.atr1),
    .set_data  (set_data),
    .tx_active (tx_active[1]),
    .rx_active (rx_active[1]),
    .fe_ctrl   (fe_ctrl1)
  );

  // --------------------------------------------------------------------------
  // Band select, codec control and timekeeping
  // --------------------------------------------------------------------------

  radio_misc_regs u_radio_misc_regs (
    .bus_clk    (bus_clk),
    .rst        (rst),
    .bandsel_wr (reg_wr.bandsel),
    .codec_wr   (reg_wr.codec),
    .pps_sel_wr (reg_wr.pps_sel),
    .set_data   (set_data),
    .band_sel   (band_sel),
    .codec_ctrl (codec_ctrl),
    .pps_sel    (pps_sel)
  );

  pps_timekeeper u_pps_timekeeper (
    .bus_clk      (bus_clk),
    .rst          (rst),
    .pps_gps      (pps_gps),
    .pps_ext      (pps_ext),
    .pps_sel      (pps_sel),
    .time_load_wr (reg_wr.time_load),
    .set_data     (set_data),
    .time_now     (time_now),
    .time_pps     (time_pps)
  );

endmodule

//--- hdl/pps_timekeeper.sv
// Tick counter with host load, and time latched on each selected PPS edge.
// Latch lands 3 cycles after the raw edge, so latched intervals are exact.

`timescale 1ns/1ns

module pps_timekeeper (
  input  logic                              bus_clk,
  input  logic                              rst,
  input  logic                              pps_gps,
  input  logic                              pps_ext,
  input  radio_ctrl_pkg::pps_src_e          pps_sel,
  input  logic                              time_load_wr,
  input  logic [radio_ctrl_pkg::DATA_W-1:0] set_data,
  output logic [radio_ctrl_pkg::DATA_W-1:0] time_now,
  output logic [radio_ctrl_pkg::DATA_W-1:0] time_pps
);

  import radio_ctrl_pkg::*;

  logic [1:0] gps_sync;
  logic [1:0] ext_sync;
  logic       pps_lvl;
  logic       pps_dly;
  logic       pps_rise;

  // --------------------------------------------------------------------------
  // Synchronize, select and edge detect
  // --------------------------------------------------------------------------

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      gps_sync <= '0;
      ext_sync <= '0;
    end else begin
      gps_sync <= {gps_sync[0], pps_gps};
      ext_sync <= {ext_sync[0], pps_ext};
    end
  end

  always_comb begin
    case (pps_sel)
      PPS_GPS:  pps_lvl = gps_sync[1];
      PPS_EXT:  pps_lvl = ext_sync[1];
      PPS_NONE: pps_lvl = 1'b0;
      default:  pps_lvl = 1'b0;
    endcase
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      pps_dly <= 1'b0;
    end else begin
      pps_dly <= pps_lvl;
    end
  end

  assign pps_rise = pps_lvl & ~pps_dly;

  // --------------------------------------------------------------------------
  // Tick counter and PPS time latch
  // --------------------------------------------------------------------------

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      time_now <= '0;
      time_pps <= '0;
    end else begin
      // Load wins over the increment, counting resumes from the loaded value
      time_now <= time_load_wr ? set_data : time_now + 1'b1;
      if (pps_rise) begin
        time_pps <= time_now;
      end
    end
  end

endmodule

//--- hdl/radio_misc_regs.sv
// Band select, codec control and PPS source registers.
// Each takes the low bits of the settings data word.

`timescale 1ns/1ns

module radio_misc_regs (
  input  logic                              bus_clk,
  input  logic                              rst,
  input  logic                              bandsel_wr,
  input  logic                              codec_wr,
  input  logic                              pps_sel_wr,
  input  logic [radio_ctrl_pkg::DATA_W-1:0] set_data,
  output radio_ctrl_pkg::band_sel_t         band_sel,
  output radio_ctrl_pkg::codec_ctrl_t       codec_ctrl,
  output radio_ctrl_pkg::pps_src_e          pps_sel
);

  import radio_ctrl_pkg::*;

  // Band selects for the TX path and the three RX groups
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      band_sel <= '0;
    end else if (bandsel_wr) begin
      band_sel <= band_sel_t'(set_data[$bits(band_sel_t)-1:0]);
    end
  end

  // MIMO mode in bit 0, codec reset in bit 1
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      codec_ctrl <= '0;
    end else if (codec_wr) begin
      codec_ctrl <= codec_ctrl_t'(set_data[$bits(codec_ctrl_t)-1:0]);
    end
  end

  // Unassigned code 3 is kept as written and decoded as no source
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      pps_sel <= PPS_NONE;
    end else if (pps_sel_wr) begin
      pps_sel <= pps_src_e'(set_data[1:0]);
    end
  end

endmodule

//--- hdl/fe_atr_ctrl.sv
// Front-end control for one channel, picked from four words by ATR state.
// Output is registered, so it lags tx_active/rx_active by one cycle.

`timescale 1ns/1ns

module fe_atr_ctrl (
  input  logic                              bus_clk,
  input  logic                              rst,
  input  logic [3:0]                        atr_wr,
  input  logic [radio_ctrl_pkg::DATA_W-1:0] set_data,
  input  logic                              tx_active,
  input  logic                              rx_active,
  output radio_ctrl_pkg::fe_ctrl_t          fe_ctrl
);

  import radio_ctrl_pkg::*;

  logic [FE_CTRL_W-1:0] atr_word [0:3];
  logic [FE_CTRL_W-1:0] cur_word;
  atr_state_e           atr_state;

  assign atr_state = atr_state_e'({tx_active, rx_active});

  // Host-written words, one per ATR state
  always_ff @(posedge bus_clk) begin
    for (int i = 0; i < 4; i++) begin
      if (rst) begin
        atr_word[i] <= '0;
      end else if (atr_wr[i]) begin
        atr_word[i] <= set_data[FE_CTRL_W-1:0];
      end
    end
  end

  always_comb begin
    case (atr_state)
      ATR_IDLE: cur_word = atr_word[0];
      ATR_RX:   cur_word = atr_word[1];
      ATR_TX:   cur_word = atr_word[2];
      ATR_FDX:  cur_word = atr_word[3];
      default:  cur_word = atr_word[0];
    endcase
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      fe_ctrl <= '0;
    end else begin
      fe_ctrl <= fe_ctrl_t'(cur_word);
    end
  end

endmodule

//--- hdl/setting_ctrl.sv
// Settings bus decoder and readback register. Every strobe is accepted.
// Writes to unmapped addresses are dropped; reads of them return RB_UNMAPPED.

`timescale 1ns/1ns

module setting_ctrl (
  input  logic                              bus_clk,
  input  logic                              rst,

  input  radio_ctrl_pkg::set_bus_t          set_bus,
  input  radio_ctrl_pkg::rb_req_t           rb_req,

  // Readback sources
  input  logic [radio_ctrl_pkg::DATA_W-1:0] time_now,
  input  logic [radio_ctrl_pkg::DATA_W-1:0] time_pps,
  input  radio_ctrl_pkg::band_sel_t         band_sel,
  input  radio_ctrl_pkg::pps_src_e          pps_sel,
  input  logic [1:0]                        lock_signals,

  output radio_ctrl_pkg::reg_wr_t           reg_wr,
  output logic [radio_ctrl_pkg::DATA_W-1:0] set_data,
  output logic [radio_ctrl_pkg::DATA_W-1:0] rb_data,
  output logic                              rb_valid
);

  import radio_ctrl_pkg::*;

  logic [DATA_W-1:0] rb_word;
  logic [DATA_W-1:0] status_word;
  logic [DATA_W-1:0] bandsel_word;

  // --------------------------------------------------------------------------
  // Write decode
  // --------------------------------------------------------------------------

  // Data goes straight through, the enables pick the target register
  assign set_data = set_bus.data;

  always_comb begin
    reg_wr = '0;
    if (set_bus.stb) begin
      case (set_bus.addr)
        ADDR_ATR0_IDLE:  reg_wr.atr0[ATR_IDLE] = 1'b1;
        ADDR_ATR0_RX:    reg_wr.atr0[ATR_RX]   = 1'b1;
        ADDR_ATR0_TX:    reg_wr.atr0[ATR_TX]   = 1'b1;
        ADDR_ATR0_FDX:   reg_wr.atr0[ATR_FDX]  = 1'b1;
        ADDR_ATR1_IDLE:  reg_wr.atr1[ATR_IDLE] = 1'b1;
        ADDR_ATR1_RX:    reg_wr.atr1[ATR_RX]   = 1'b1;
        ADDR_ATR1_TX:    reg_wr.atr1[ATR_TX]   = 1'b1;
        ADDR_ATR1_FDX:   reg_wr.atr1[ATR_FDX]  = 1'b1;
        ADDR_BANDSEL:    reg_wr.bandsel        = 1'b1;
        ADDR_CODEC_CTRL: reg_wr.codec          = 1'b1;
        ADDR_PPS_SEL:    reg_wr.pps_sel        = 1'b1;
        ADDR_TIME_LOAD:  reg_wr.time_load      = 1'b1;
        default:         reg_wr                = '0;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Readback mux
  // --------------------------------------------------------------------------

  // Lock bits in 1:0, PPS source in 5:4
  assign status_word = {{(DATA_W-6){1'b0}}, pps_sel, 2'b00, lock_signals};

  assign bandsel_word = {{(DATA_W-$bits(band_sel_t)){1'b0}}, band_sel};

  always_comb begin
    case (rb_req.addr)
      RB_TIME_NOW: rb_word = time_now;
      RB_TIME_PPS: rb_word = time_pps;
      RB_STATUS:   rb_word = status_word;
      RB_BANDSEL:  rb_word = bandsel_word;
      default:     rb_word = RB_UNMAPPED;
    endcase
  end

  // One request per cycle, answer one cycle later
  always_ff @(posedge bus_clk) begin
    if (rst) begin
      rb_valid <= 1'b0;
    end else begin
      rb_valid <= rb_req.stb;
    end
  end

  // Data only matters while rb_valid is high
  always_ff @(posedge bus_clk) begin
    if (rb_req.stb) begin
      rb_data <= rb_word;
    end
  end

endmodule

//--- hdl/radio_ctrl_pkg.sv
// Shared address map, widths and bus structs for the radio control block.
// Packed struct members are listed MSB first, so the last member sits at bit 0.

package radio_ctrl_pkg;

  // --------------------------------------------------------------------------
  // Widths and constants
  // --------------------------------------------------------------------------

  localparam int SET_ADDR_W = 8;
  localparam int DATA_W     = 32;
  localparam int FE_CTRL_W  = 9;

  localparam logic [DATA_W-1:0] RB_UNMAPPED = 32'hdead_beef;

  // --------------------------------------------------------------------------
  // Address map and codes
  // --------------------------------------------------------------------------

  // Settings bus write addresses
  typedef enum logic [SET_ADDR_W-1:0] {
    ADDR_ATR0_IDLE  = 8'h00,
    ADDR_ATR0_RX    = 8'h01,
    ADDR_ATR0_TX    = 8'h02,
    ADDR_ATR0_FDX   = 8'h03,
    ADDR_ATR1_IDLE  = 8'h04,
    ADDR_ATR1_RX    = 8'h05,
    ADDR_ATR1_TX    = 8'h06,
    ADDR_ATR1_FDX   = 8'h07,
    ADDR_BANDSEL    = 8'h08,
    ADDR_CODEC_CTRL = 8'h09,
    ADDR_PPS_SEL    = 8'h0A,
    ADDR_TIME_LOAD  = 8'h0B
  } set_addr_e;

  // Readback addresses
  typedef enum logic [SET_ADDR_W-1:0] {
    RB_TIME_NOW = 8'h00,
    RB_TIME_PPS = 8'h01,
    RB_STATUS   = 8'h02,
    RB_BANDSEL  = 8'h03
  } rb_addr_e;

  // ATR state is {tx, rx}
  typedef enum logic [1:0] {
    ATR_IDLE = 2'b00,
    ATR_RX   = 2'b01,
    ATR_TX   = 2'b10,
    ATR_FDX  = 2'b11
  } atr_state_e;

  // Code 3 is unassigned and acts as no source
  typedef enum logic [1:0] {
    PPS_NONE = 2'd0,
    PPS_GPS  = 2'd1,
    PPS_EXT  = 2'd2
  } pps_src_e;

  // --------------------------------------------------------------------------
  // Bus and register structs
  // --------------------------------------------------------------------------

  typedef struct packed {
    logic                  stb;
    logic [SET_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     data;
  } set_bus_t;

  typedef struct packed {
    logic                  stb;
    logic [SET_ADDR_W-1:0] addr;
  } rb_req_t;

  // Same order as the board's front-end gpio bits 10 to 18
  typedef struct packed {
    logic led_txrx_tx;
    logic led_txrx_rx;
    logic led_rx_rx;
    logic vcrx_v2;
    logic vcrx_v1;
    logic vctxrx_v2;
    logic vctxrx_v1;
    logic tx_enable_b;
    logic tx_enable_a;
  } fe_ctrl_t;

  typedef struct packed {
    logic [3:0] rx_bandsel_c;
    logic [3:0] rx_bandsel_b;
    logic [5:0] rx_bandsel_a;
    logic [2:0] tx_bandsel;
  } band_sel_t;

  typedef struct packed {
    logic codec_rst;
    logic mimo;
  } codec_ctrl_t;

  // One-hot write enables, ATR fields indexed by atr_state_e
  typedef struct packed {
    logic [3:0] atr0;
    logic [3:0] atr1;
    logic       bandsel;
    logic       codec;
    logic       pps_sel;
    logic       time_load;
  } reg_wr_t;

endpackage
